//--- hw/csr_axil_slave.sv
`timescale 1ns/1ns
`default_nettype none

module csr_axil_slave import csr_pkg::*; (
   input  wire              i_clk,
   input  wire              i_rst_n,
   input  wire              i_awvalid,
   output logic             o_awready,
   input  wire [ADDR_W-1:0] i_awaddr,
   input  wire              i_wvalid,
   output logic             o_wready,
   input  wire [CSR_W-1:0]  i_wdata,
   output logic             o_bvalid,
   input  wire              i_bready,
   output wire [1:0]        o_bresp,
   input  wire              i_arvalid,
   output logic             o_arready,
   input  wire [ADDR_W-1:0] i_araddr,
   output logic             o_rvalid,
   input  wire              i_rready,
   output wire [CSR_W-1:0]  o_rdata,
   output wire [1:0]        o_rresp,
   output logic             o_req,
   output logic [2:0]       o_req_idx,
   output csr_op_e          o_req_op,
   output wire              o_d,
   input  wire              i_shift,
   input  wire              i_q,
   input  wire              i_acc_done
);

   logic             busy;
   logic             is_write;
   logic             wr_go;
   logic             rd_go;
   logic [CSR_W-1:0] op_sr;
   logic [CSR_W-1:0] rd_sr;
   csr_op_e          wr_op;

   assign wr_go = o_awready & i_awvalid & o_wready & i_wvalid;
   assign rd_go = o_arready & i_arvalid;

   // A write with kind bits 00 is a plain write
   assign wr_op = (i_awaddr[ADDR_OP_HI:ADDR_OP_LO] == 2'b00) ? OP_WRITE :
                  csr_op_e'(i_awaddr[ADDR_OP_HI:ADDR_OP_LO]);

   assign o_d = op_sr[0];
   assign o_rdata = rd_sr;
   assign o_bresp = RESP_OKAY;
   assign o_rresp = RESP_OKAY;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_awready <= 1'b0;
         o_wready <= 1'b0;
         o_arready <= 1'b0;
         o_bvalid <= 1'b0;
         o_rvalid <= 1'b0;
         o_req <= 1'b0;
         o_req_idx <= CSR_NONE;
         o_req_op <= OP_KEEP;
         busy <= 1'b0;
         is_write <= 1'b0;
      end else begin
         o_req <= wr_go | rd_go;
         o_awready <= 1'b0;
         o_wready <= 1'b0;
         o_arready <= 1'b0;
         // Writes win a tie with a waiting read
         if (!busy && !o_awready && !o_arready) begin
            if (i_awvalid && i_wvalid) begin
               o_awready <= 1'b1;
               o_wready <= 1'b1;
            end else if (i_arvalid) begin
               o_arready <= 1'b1;
            end
         end
         if (wr_go) begin
            busy <= 1'b1;
            is_write <= 1'b1;
            o_req_op <= wr_op;
            o_req_idx <= i_awaddr[ADDR_IDX_HI] ? CSR_NONE :
                         i_awaddr[ADDR_IDX_HI-1:ADDR_IDX_LO];
         end else if (rd_go) begin
            busy <= 1'b1;
            is_write <= 1'b0;
            o_req_op <= OP_KEEP;
            o_req_idx <= i_araddr[ADDR_IDX_HI] ? CSR_NONE :
                         i_araddr[ADDR_IDX_HI-1:ADDR_IDX_LO];
         end
         if (i_acc_done) begin
            if (is_write)
               o_bvalid <= 1'b1;
            else
               o_rvalid <= 1'b1;
         end
         if (o_bvalid && i_bready) begin
            o_bvalid <= 1'b0;
            busy <= 1'b0;
         end
         if (o_rvalid && i_rready) begin
            o_rvalid <= 1'b0;
            busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n)
         rd_sr <= '0;
      else if (i_shift)
         rd_sr <= {i_q, rd_sr[CSR_W-1:1]};
   end

   // Operand goes out LSB first
   always_ff @(posedge i_clk) begin
      if (wr_go)
         op_sr <= i_wdata;
      else if (i_shift)
         op_sr <= op_sr >> 1;
   end

endmodule

`default_nettype wire

//--- hw/csr_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module csr_ctrl import csr_pkg::*; (
   input  wire             i_clk,
   input  wire             i_rst_n,
   input  wire             i_req,
   input  wire [2:0]       i_req_idx,
   input  wire csr_op_e    i_req_op,
   input  wire             i_trap_valid,
   input  wire [CSR_W-1:0] i_trap_pc,
   output logic            o_trap_done,
   input  wire             i_mret_valid,
   output logic            o_mret_done,
   input  wire             i_resp_taken,
   output wire             o_shift,
   output logic            o_acc_done,
   output wire             o_en,
   output wire             o_cnt0to3,
   output wire             o_cnt3,
   output wire             o_cnt7,
   output wire             o_cnt_done,
   output csr_op_e         o_op,
   output wire             o_sel_mstatus,
   output wire             o_sel_mie,
   output wire             o_sel_mcause,
   output wire             o_sel_mscratch,
   output wire             o_sel_mepc,
   output wire             o_sel_mtvec,
   output wire             o_sel_mtimecmp,
   output logic            o_trap_taken,
   output wire             o_mret,
   output wire             o_pc_bit,
   output wire             o_pc_load
);

   ctrl_state_e      state;
   logic [4:0]       cnt;
   logic             req_pend;
   logic             acc;
   logic             trap;
   logic [CSR_W-1:0] pc_sr;

   assign acc = state == ST_ACCESS;
   assign trap = state == ST_TRAP;

   assign o_en = acc | trap;
   assign o_shift = acc;
   assign o_cnt0to3 = cnt[4:2] == 3'd0;
   assign o_cnt3 = cnt == 5'(MSTATUS_MIE_BIT);
   assign o_cnt7 = cnt == 5'(MIE_MTIE_BIT);
   assign o_cnt_done = &cnt;

   assign o_op = trap ? OP_WRITE : acc ? i_req_op : OP_KEEP;

   assign o_sel_mstatus = acc && i_req_idx == CSR_MSTATUS;
   assign o_sel_mie = acc && i_req_idx == CSR_MIE;
   assign o_sel_mcause = acc && i_req_idx == CSR_MCAUSE;
   assign o_sel_mscratch = acc && i_req_idx == CSR_MSCRATCH;
   assign o_sel_mepc = (acc && i_req_idx == CSR_MEPC) || trap;
   assign o_sel_mtvec = acc && i_req_idx == CSR_MTVEC;
   assign o_sel_mtimecmp = acc && i_req_idx == CSR_MTIMECMP;

   assign o_mret = state == ST_MRET;
   assign o_pc_bit = pc_sr[0];
   assign o_pc_load = trap;

   // ####################
   // Sequencing

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= ST_IDLE;
         cnt <= 5'd0;
         req_pend <= 1'b0;
         o_trap_taken <= 1'b0;
         o_trap_done <= 1'b0;
         o_mret_done <= 1'b0;
         o_acc_done <= 1'b0;
      end else begin
         o_trap_taken <= 1'b0;
         o_trap_done <= 1'b0;
         o_mret_done <= 1'b0;
         o_acc_done <= 1'b0;
         if (o_en)
            cnt <= cnt + 5'd1;
         // A host request that arrives during a trap waits here
         if (i_req)
            req_pend <= 1'b1;
         unique case (state)
            ST_IDLE: begin
               if (i_trap_valid && !o_trap_done) begin
                  state <= ST_TRAP;
                  o_trap_taken <= 1'b1;
               end else if (i_mret_valid && !o_mret_done) begin
                  state <= ST_MRET;
               end else if (i_req || req_pend) begin
                  state <= ST_ACCESS;
                  req_pend <= 1'b0;
               end
            end
            ST_ACCESS: begin
               if (o_cnt_done) begin
                  state <= ST_RESP;
                  o_acc_done <= 1'b1;
               end
            end
            ST_TRAP: begin
               if (o_cnt_done) begin
                  state <= ST_IDLE;
                  o_trap_done <= 1'b1;
               end
            end
            ST_MRET: begin
               state <= ST_IDLE;
               o_mret_done <= 1'b1;
            end
            ST_RESP: begin
               if (i_resp_taken)
                  state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Trap pc is held by the core, so it can be reloaded every idle cycle
   always_ff @(posedge i_clk) begin
      if (state == ST_IDLE)
         pc_sr <= i_trap_pc;
      else if (trap)
         pc_sr <= pc_sr >> 1;
   end

endmodule

`default_nettype wire

//--- hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

   localparam int CSR_W = 32;
   localparam int ADDR_W = 8;
   localparam int NUM_STORE = 3;

   // Byte address fields
   localparam int ADDR_IDX_HI = 5;
   localparam int ADDR_IDX_LO = 2;
   localparam int ADDR_OP_HI = 7;
   localparam int ADDR_OP_LO = 6;

   localparam logic [2:0] CSR_MSTATUS = 3'd0;
   localparam logic [2:0] CSR_MIE = 3'd1;
   localparam logic [2:0] CSR_MCAUSE = 3'd2;
   localparam logic [2:0] CSR_MSCRATCH = 3'd3;
   localparam logic [2:0] CSR_MEPC = 3'd4;
   localparam logic [2:0] CSR_MTVEC = 3'd5;
   localparam logic [2:0] CSR_MTIMECMP = 3'd6;
   // Index that selects no register, so reads return zero
   localparam logic [2:0] CSR_NONE = 3'd7;

   localparam int MSTATUS_MIE_BIT = 3;
   localparam int MIE_MTIE_BIT = 7;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   typedef enum logic [1:0] {
      OP_KEEP  = 2'b00,
      OP_WRITE = 2'b01,
      OP_SET   = 2'b10,
      OP_CLEAR = 2'b11
   } csr_op_e;

   typedef enum logic [3:0] {
      CAUSE_EBREAK         = 4'd3,
      CAUSE_MISALIGN_LOAD  = 4'd4,
      CAUSE_MISALIGN_STORE = 4'd6,
      CAUSE_TIMER_IRQ      = 4'd7,
      CAUSE_ECALL          = 4'd11
   } trap_cause_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_ACCESS,
      ST_TRAP,
      ST_MRET,
      ST_RESP
   } ctrl_state_e;

endpackage

`default_nettype wire

//--- hw/csr_state.sv
`timescale 1ns/1ns
`default_nettype none

module csr_state import csr_pkg::*; (
   input  wire              i_clk,
   input  wire              i_rst_n,
   input  wire              i_en,
   input  wire              i_cnt0to3,
   input  wire              i_cnt3,
   input  wire              i_cnt7,
   input  wire              i_cnt_done,
   input  wire              i_sel_mstatus,
   input  wire              i_sel_mie,
   input  wire              i_sel_mcause,
   input  wire csr_op_e     i_op,
   input  wire              i_d,
   input  wire              i_pc_bit,
   input  wire              i_pc_load,
   input  wire              i_rf_q,
   input  wire              i_trap_taken,
   input  wire trap_cause_e i_trap_cause,
   input  wire              i_mret,
   input  wire              i_mtip,
   output wire              o_csr_in,
   output wire              o_q,
   output wire              o_irq
);

   logic       mstatus_mie;
   logic       mstatus_mpie;
   logic       mie_mtie;
   logic       mcause31;
   logic [3:0] mcause3_0;
   logic       mcause_bit;
   logic       csr_out;
   logic       csr_in;
   logic       timer_irq;
   logic       timer_irq_r;

   // mcause only has bits 3:0 and 31
   assign mcause_bit = i_cnt0to3 ? mcause3_0[0] : (i_cnt_done & mcause31);

   assign csr_out = (i_sel_mstatus & i_cnt3 & mstatus_mie) |
                    (i_sel_mie & i_cnt7 & mie_mtie) |
                    (i_sel_mcause & i_en & mcause_bit) |
                    i_rf_q;

   always_comb begin
      if (i_pc_load) begin
         csr_in = i_pc_bit;
      end else begin
         unique case (i_op)
            OP_WRITE: csr_in = i_d;
            OP_SET:   csr_in = csr_out | i_d;
            OP_CLEAR: csr_in = csr_out & ~i_d;
            default:  csr_in = csr_out;
         endcase
      end
   end

   assign o_csr_in = csr_in;
   assign o_q = csr_out;

   assign timer_irq = i_mtip & mstatus_mie & mie_mtie;
   assign o_irq = timer_irq & ~timer_irq_r;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mstatus_mie <= 1'b0;
         mstatus_mpie <= 1'b0;
         mie_mtie <= 1'b0;
         mcause31 <= 1'b0;
         mcause3_0 <= 4'd0;
         timer_irq_r <= 1'b0;
      end else begin
         timer_irq_r <= timer_irq;
         if (i_sel_mstatus && i_cnt3)
            mstatus_mie <= csr_in;
         if (i_sel_mie && i_cnt7)
            mie_mtie <= csr_in;
         if (i_sel_mcause && i_en) begin
            if (i_cnt0to3)
               mcause3_0 <= {csr_in, mcause3_0[3:1]};
            if (i_cnt_done)
               mcause31 <= csr_in;
         end
         if (i_mret)
            mstatus_mie <= mstatus_mpie;
         if (i_trap_taken) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie <= 1'b0;
            mcause31 <= i_trap_cause == CAUSE_TIMER_IRQ;
            mcause3_0 <= i_trap_cause;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/csr_store.sv
`timescale 1ns/1ns
`default_nettype none

module csr_store import csr_pkg::*; (
   input  wire  i_clk,
   input  wire  i_rst_n,
   input  wire  i_en,
   input  wire  i_sel_mscratch,
   input  wire  i_sel_mepc,
   input  wire  i_sel_mtvec,
   input  wire  i_csr_in,
   output wire  o_q
);

   logic [NUM_STORE-1:0]            sel;
   logic [NUM_STORE-1:0][CSR_W-1:0] regs;
   logic [NUM_STORE-1:0]            q_bits;

   assign sel = {i_sel_mtvec, i_sel_mepc, i_sel_mscratch};

   // Each register rotates right, new bit in at the top
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         regs <= '0;
      end else begin
         for (int i = 0; i < NUM_STORE; i++) begin
            if (i_en && sel[i])
               regs[i] <= {i_csr_in, regs[i][CSR_W-1:1]};
         end
      end
   end

   for (genvar g = 0; g < NUM_STORE; g++) begin : g_q
      assign q_bits[g] = sel[g] & regs[g][0];
   end

   assign o_q = |q_bits;

endmodule

`default_nettype wire

//--- hw/csr_timer.sv
`timescale 1ns/1ns
`default_nettype none

module csr_timer import csr_pkg::*; (
   input  wire  i_clk,
   input  wire  i_rst_n,
   input  wire  i_en,
   input  wire  i_sel_mtimecmp,
   input  wire  i_csr_in,
   output wire  o_q,
   output logic o_mtip
);

   logic [CSR_W-1:0] mtime;
   logic [CSR_W-1:0] mtimecmp;
   logic             cmp_pass;

   assign cmp_pass = i_en & i_sel_mtimecmp;
   assign o_q = cmp_pass & mtimecmp[0];

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mtime <= '0;
         mtimecmp <= '1;
         o_mtip <= 1'b0;
      end else begin
         mtime <= mtime + 1'b1;
         if (cmp_pass)
            mtimecmp <= {i_csr_in, mtimecmp[CSR_W-1:1]};
         else
            o_mtip <= mtime >= mtimecmp;
         // mtip holds its value while mtimecmp is half rotated
      end
   end

endmodule

`default_nettype wire

//--- hw/csr_top.sv
`timescale 1ns/1ns
`default_nettype none

module csr_top import csr_pkg::*; (
   input  wire              i_clk,
   input  wire              i_rst_n,
   input  wire              i_awvalid,
   output wire              o_awready,
   input  wire [ADDR_W-1:0] i_awaddr,
   input  wire              i_wvalid,
   output wire              o_wready,
   input  wire [CSR_W-1:0]  i_wdata,
   output wire              o_bvalid,
   input  wire              i_bready,
   output wire [1:0]        o_bresp,
   input  wire              i_arvalid,
   output wire              o_arready,
   input  wire [ADDR_W-1:0] i_araddr,
   output wire              o_rvalid,
   input  wire              i_rready,
   output wire [CSR_W-1:0]  o_rdata,
   output wire [1:0]        o_rresp,
   input  wire              i_trap_valid,
   input  wire trap_cause_e i_trap_cause,
   input  wire [CSR_W-1:0]  i_trap_pc,
   output wire              o_trap_done,
   input  wire              i_mret_valid,
   output wire              o_mret_done,
   output wire              o_irq
);

   wire       req;
   wire [2:0] req_idx;
   csr_op_e   req_op;
   csr_op_e   op;
   wire       d;
   wire       shift;
   wire       q;
   wire       acc_done;
   wire       resp_taken;
   wire       en;
   wire       cnt0to3;
   wire       cnt3;
   wire       cnt7;
   wire       cnt_done;
   wire       sel_mstatus;
   wire       sel_mie;
   wire       sel_mcause;
   wire       sel_mscratch;
   wire       sel_mepc;
   wire       sel_mtvec;
   wire       sel_mtimecmp;
   wire       trap_taken;
   wire       mret;
   wire       pc_bit;
   wire       pc_load;
   wire       csr_in;
   wire       store_q;
   wire       timer_q;
   wire       mtip;

   assign resp_taken = (o_bvalid & i_bready) | (o_rvalid & i_rready);

   // ####################
   // Host side

   csr_axil_slave slave_inst (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_awvalid  (i_awvalid),
      .o_awready  (o_awready),
      .i_awaddr   (i_awaddr),
      .i_wvalid   (i_wvalid),
      .o_wready   (o_wready),
      .i_wdata    (i_wdata),
      .o_bvalid   (o_bvalid),
      .i_bready   (i_bready),
      .o_bresp    (o_bresp),
      .i_arvalid  (i_arvalid),
      .o_arready  (o_arready),
      .i_araddr   (i_araddr),
      .o_rvalid   (o_rvalid),
      .i_rready   (i_rready),
      .o_rdata    (o_rdata),
      .o_rresp    (o_rresp),
      .o_req      (req),
      .o_req_idx  (req_idx),
      .o_req_op   (req_op),
      .o_d        (d),
      .i_shift    (shift),
      .i_q        (q),
      .i_acc_done (acc_done)
   );

   csr_ctrl ctrl_inst (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_req          (req),
      .i_req_idx      (req_idx),
      .i_req_op       (req_op),
      .i_trap_valid   (i_trap_valid),
      .i_trap_pc      (i_trap_pc),
      .o_trap_done    (o_trap_done),
      .i_mret_valid   (i_mret_valid),
      .o_mret_done    (o_mret_done),
      .i_resp_taken   (resp_taken),
      .o_shift        (shift),
      .o_acc_done     (acc_done),
      .o_en           (en),
      .o_cnt0to3      (cnt0to3),
      .o_cnt3         (cnt3),
      .o_cnt7         (cnt7),
      .o_cnt_done     (cnt_done),
      .o_op           (op),
      .o_sel_mstatus  (sel_mstatus),
      .o_sel_mie      (sel_mie),
      .o_sel_mcause   (sel_mcause),
      .o_sel_mscratch (sel_mscratch),
      .o_sel_mepc     (sel_mepc),
      .o_sel_mtvec    (sel_mtvec),
      .o_sel_mtimecmp (sel_mtimecmp),
      .o_trap_taken   (trap_taken),
      .o_mret         (mret),
      .o_pc_bit       (pc_bit),
      .o_pc_load      (pc_load)
   );

   // ####################
   // Serial datapath

   csr_state state_inst (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_en          (en),
      .i_cnt0to3     (cnt0to3),
      .i_cnt3        (cnt3),
      .i_cnt7        (cnt7),
      .i_cnt_done    (cnt_done),
      .i_sel_mstatus (sel_mstatus),
      .i_sel_mie     (sel_mie),
      .i_sel_mcause  (sel_mcause),
      .i_op          (op),
      .i_d           (d),
      .i_pc_bit      (pc_bit),
      .i_pc_load     (pc_load),
      .i_rf_q        (store_q | timer_q),
      .i_trap_taken  (trap_taken),
      .i_trap_cause  (i_trap_cause),
      .i_mret        (mret),
      .i_mtip        (mtip),
      .o_csr_in      (csr_in),
      .o_q           (q),
      .o_irq         (o_irq)
   );

   csr_store store_inst (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_en           (en),
      .i_sel_mscratch (sel_mscratch),
      .i_sel_mepc     (sel_mepc),
      .i_sel_mtvec    (sel_mtvec),
      .i_csr_in       (csr_in),
      .o_q            (store_q)
   );

   csr_timer timer_inst (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_en           (en),
      .i_sel_mtimecmp (sel_mtimecmp),
      .i_csr_in       (csr_in),
      .o_q            (timer_q),
      .o_mtip         (mtip)
   );

endmodule

`default_nettype wire

//--- test/csr_checker.sv
`timescale 1ns/1ns
`default_nettype none

module csr_checker (
   input wire i_clk,
   input wire i_rst_n,
   input wire i_awready,
   input wire i_wready,
   input wire i_bvalid,
   input wire i_bready,
   input wire i_rvalid,
   input wire i_rready,
   input wire i_irq
);

   int fail_count = 0;

   // Responses stay up until the host takes them
   a_bvalid_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_bvalid && !i_bready |=> i_bvalid)
      else begin
         $error("bvalid dropped before bready was seen");
         fail_count++;
      end

   a_rvalid_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_rvalid && !i_rready |=> i_rvalid)
      else begin
         $error("rvalid dropped before rready was seen");
         fail_count++;
      end

   a_irq_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_irq |=> !i_irq)
      else begin
         $error("irq stayed high for two cycles");
         fail_count++;
      end

   a_aw_with_w: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $rose(i_awready) |-> i_wready)
      else begin
         $error("awready rose without wready");
         fail_count++;
      end

endmodule

`default_nettype wire

//--- test/csr_tb.sv
`timescale 1ns/1ns
`default_nettype none

module csr_tb import csr_pkg::*; ();

   localparam int CLK_PERIOD = 8;
   localparam int N_ROUNDS = 8;
   localparam int N_TRAPS = 4;
   localparam int ACCESS_COUNT = 6 * N_ROUNDS + (2 + 4 * N_ROUNDS) + 6 * N_ROUNDS +
                                 8 * N_TRAPS + 16;
   localparam int WATCHDOG_CYCLES = ACCESS_COUNT * 60 + 500;
   localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

   logic              clk;
   logic              rst_n;
   logic              awvalid;
   logic              wvalid;
   logic              bready;
   logic              arvalid;
   logic              rready;
   logic [ADDR_W-1:0] awaddr;
   logic [ADDR_W-1:0] araddr;
   logic [CSR_W-1:0]  wdata;
   wire               awready;
   wire               wready;
   wire               bvalid;
   wire               arready;
   wire               rvalid;
   wire [1:0]         bresp;
   wire [1:0]         rresp;
   wire [CSR_W-1:0]   rdata;
   logic              trap_valid;
   trap_cause_e       trap_cause;
   logic [CSR_W-1:0]  trap_pc;
   wire               trap_done;
   logic              mret_valid;
   wire               mret_done;
   wire               irq;

   logic [31:0] lfsr;
   logic [31:0] model [0:6];
   logic        model_mpie;
   string       names [0:6] = '{"mstatus", "mie", "mcause", "mscratch", "mepc", "mtvec",
                                "mtimecmp"};
   int          checks;
   int          errors;
   int          test_checks;
   int          test_errors;
   int          irq_count;

   tb_clkgen clkgen_inst (
      .o_clk   (clk),
      .o_rst_n (rst_n)
   );

   csr_top csr_top_inst (
      .i_clk        (clk),
      .i_rst_n      (rst_n),
      .i_awvalid    (awvalid),
      .o_awready    (awready),
      .i_awaddr     (awaddr),
      .i_wvalid     (wvalid),
      .o_wready     (wready),
      .i_wdata      (wdata),
      .o_bvalid     (bvalid),
      .i_bready     (bready),
      .o_bresp      (bresp),
      .i_arvalid    (arvalid),
      .o_arready    (arready),
      .i_araddr     (araddr),
      .o_rvalid     (rvalid),
      .i_rready     (rready),
      .o_rdata      (rdata),
      .o_rresp      (rresp),
      .i_trap_valid (trap_valid),
      .i_trap_cause (trap_cause),
      .i_trap_pc    (trap_pc),
      .o_trap_done  (trap_done),
      .i_mret_valid (mret_valid),
      .o_mret_done  (mret_done),
      .o_irq        (irq)
   );

   bind csr_top csr_checker csr_checker_inst (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_awready (o_awready),
      .i_wready  (o_wready),
      .i_bvalid  (o_bvalid),
      .i_bready  (i_bready),
      .i_rvalid  (o_rvalid),
      .i_rready  (i_rready),
      .i_irq     (o_irq)
   );

   // ####################
   // Helpers

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic get_random(input int nbits, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr_next(lfsr);
         value = {value[30:0], lfsr[0]};
      end
   endtask

   // Only a few bits of the status CSRs exist, everything else reads zero
   function automatic logic [31:0] next_value(input logic [2:0] idx, input logic [1:0] kind,
                                              input logic [31:0] old, input logic [31:0] data);
      logic [31:0] mask;
      logic [31:0] value;
      case (idx)
         CSR_MSTATUS: mask = 32'h1 << MSTATUS_MIE_BIT;
         CSR_MIE:     mask = 32'h1 << MIE_MTIE_BIT;
         CSR_MCAUSE:  mask = 32'h8000_000F;
         default:     mask = 32'hFFFF_FFFF;
      endcase
      if (kind == OP_SET)
         value = old | data;
      else if (kind == OP_CLEAR)
         value = old & ~data;
      else
         value = data;
      return value & mask;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic begin_test();
      test_checks = checks;
      test_errors = errors;
   endtask

   task automatic end_test(input string name);
      $display("Test %s: %0d checks, %0d errors", name, checks - test_checks,
               errors - test_errors);
   endtask

   // ####################
   // Bus and core tasks

   task automatic write_csr(input logic [2:0] idx, input logic [1:0] kind,
                            input logic [31:0] data);
      logic [31:0] delay;
      get_random(2, delay);
      awaddr = {kind, 1'b0, idx, 2'b00};
      wdata = data;
      awvalid = 1'b1;
      wvalid = 1'b1;
      @(negedge clk);
      while (!awready)
         @(negedge clk);
      @(posedge clk);
      #1;
      awvalid = 1'b0;
      wvalid = 1'b0;
      @(negedge clk);
      while (!bvalid)
         @(negedge clk);
      check_value("bresp", 32'(bresp), 32'(AXI_RESP_OKAY));
      @(posedge clk);
      repeat (delay) @(posedge clk);
      #1 bready = 1'b1;
      @(posedge clk);
      #1 bready = 1'b0;
      model[idx] = next_value(idx, kind, model[idx], data);
   endtask

   task automatic read_check(input logic [2:0] idx);
      logic [31:0] delay;
      get_random(2, delay);
      araddr = {3'b000, idx, 2'b00};
      arvalid = 1'b1;
      @(negedge clk);
      while (!arready)
         @(negedge clk);
      @(posedge clk);
      #1 arvalid = 1'b0;
      @(negedge clk);
      while (!rvalid)
         @(negedge clk);
      check_value(names[idx], rdata, model[idx]);
      check_value("rresp", 32'(rresp), 32'(AXI_RESP_OKAY));
      @(posedge clk);
      repeat (delay) @(posedge clk);
      #1 rready = 1'b1;
      @(posedge clk);
      #1 rready = 1'b0;
   endtask

   task automatic take_trap(input trap_cause_e cause, input logic [31:0] pc);
      trap_cause = cause;
      trap_pc = pc;
      trap_valid = 1'b1;
      @(negedge clk);
      while (!trap_done)
         @(negedge clk);
      @(posedge clk);
      #1 trap_valid = 1'b0;
      model[CSR_MEPC] = pc;
      model[CSR_MCAUSE] = {cause == CAUSE_TIMER_IRQ, 27'd0, cause};
      model_mpie = model[CSR_MSTATUS][MSTATUS_MIE_BIT];
      model[CSR_MSTATUS] = '0;
   endtask

   task automatic return_from_trap();
      mret_valid = 1'b1;
      @(negedge clk);
      while (!mret_done)
         @(negedge clk);
      @(posedge clk);
      #1 mret_valid = 1'b0;
      model[CSR_MSTATUS] = 32'(model_mpie) << MSTATUS_MIE_BIT;
   endtask

   always @(negedge clk) begin
      if (rst_n && irq)
         irq_count++;
   end

   // ####################
   // Tests

   initial begin
      logic [31:0] value;
      logic [31:0] rnd;
      trap_cause_e cause;
      awvalid = 1'b0;
      wvalid = 1'b0;
      bready = 1'b0;
      arvalid = 1'b0;
      rready = 1'b0;
      awaddr = '0;
      araddr = '0;
      wdata = '0;
      trap_valid = 1'b0;
      trap_cause = CAUSE_EBREAK;
      trap_pc = '0;
      mret_valid = 1'b0;
      lfsr = 32'h4311;
      checks = 0;
      errors = 0;
      irq_count = 0;
      model_mpie = 1'b0;
      for (int i = 0; i < 7; i++)
         model[i] = '0;
      model[CSR_MTIMECMP] = '1;
      @(posedge rst_n);
      wait_cycles(1);

      begin_test();
      for (int i = 0; i < N_ROUNDS; i++) begin
         for (int r = CSR_MSCRATCH; r <= CSR_MTVEC; r++) begin
            get_random(32, value);
            write_csr(3'(r), OP_WRITE, value);
            read_check(3'(r));
         end
      end
      end_test("1 write and read of mscratch, mepc, mtvec");

      begin_test();
      get_random(32, value);
      write_csr(CSR_MSCRATCH, OP_WRITE, value);
      read_check(CSR_MSCRATCH);
      for (int i = 0; i < N_ROUNDS; i++) begin
         get_random(32, value);
         write_csr(CSR_MSCRATCH, OP_SET, value);
         read_check(CSR_MSCRATCH);
         get_random(32, value);
         write_csr(CSR_MSCRATCH, OP_CLEAR, value);
         read_check(CSR_MSCRATCH);
      end
      end_test("2 set and clear on mscratch");

      // Kind bits 00 and 01 both act as a plain write
      begin_test();
      for (int i = 0; i < N_ROUNDS; i++) begin
         for (int r = CSR_MSTATUS; r <= CSR_MCAUSE; r++) begin
            get_random(32, value);
            get_random(1, rnd);
            write_csr(3'(r), {1'b0, rnd[0]}, value);
            read_check(3'(r));
         end
      end
      end_test("3 masked status CSRs");

      begin_test();
      for (int i = 0; i < N_TRAPS; i++) begin
         get_random(32, value);
         write_csr(CSR_MSTATUS, OP_WRITE, value);
         get_random(3, rnd);
         case (rnd % 5)
            0: cause = CAUSE_MISALIGN_LOAD;
            1: cause = CAUSE_MISALIGN_STORE;
            2: cause = CAUSE_EBREAK;
            3: cause = CAUSE_ECALL;
            default: cause = CAUSE_TIMER_IRQ;
         endcase
         get_random(32, value);
         take_trap(cause, value);
         read_check(CSR_MEPC);
         read_check(CSR_MCAUSE);
         read_check(CSR_MSTATUS);
         return_from_trap();
         read_check(CSR_MSTATUS);
      end
      end_test("4 trap entry and mret");

      begin_test();
      write_csr(CSR_MIE, OP_WRITE, '0);
      write_csr(CSR_MSTATUS, OP_WRITE, '0);
      irq_count = 0;
      // mtimecmp still at its reset value, so mtip never rises
      write_csr(CSR_MIE, OP_WRITE, 32'h1 << MIE_MTIE_BIT);
      write_csr(CSR_MSTATUS, OP_WRITE, 32'h1 << MSTATUS_MIE_BIT);
      wait_cycles(40);
      check_value("irq pulses with mtimecmp at reset", irq_count, 0);
      write_csr(CSR_MSTATUS, OP_WRITE, '0);
      write_csr(CSR_MIE, OP_WRITE, '0);
      write_csr(CSR_MTIMECMP, OP_WRITE, '0);
      read_check(CSR_MTIMECMP);
      write_csr(CSR_MSTATUS, OP_WRITE, 32'h1 << MSTATUS_MIE_BIT);
      wait_cycles(40);
      check_value("irq pulses with mtie clear", irq_count, 0);
      write_csr(CSR_MSTATUS, OP_WRITE, '0);
      write_csr(CSR_MIE, OP_SET, 32'h1 << MIE_MTIE_BIT);
      write_csr(CSR_MSTATUS, OP_SET, 32'h1 << MSTATUS_MIE_BIT);
      wait_cycles(40);
      check_value("irq pulses when enabled", irq_count, 1);
      read_check(CSR_MIE);
      read_check(CSR_MSTATUS);
      end_test("5 timer interrupt");

      errors += csr_top_inst.csr_checker_inst.fail_count;
      $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- test/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
   output logic o_clk,
   output logic o_rst_n
);

   localparam int HALF_PERIOD = 4;
   localparam int RESET_CYCLES = 3;

   initial begin
      o_clk = 1'b0;
      forever #(HALF_PERIOD) o_clk = ~o_clk;
   end

   initial begin
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      #1 o_rst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- vlog.f
hw/csr_pkg.sv
hw/csr_axil_slave.sv
hw/csr_ctrl.sv
hw/csr_state.sv
hw/csr_store.sv
hw/csr_timer.sv
hw/csr_top.sv
test/tb_clkgen.sv
test/csr_checker.sv
test/csr_tb.sv
